/* cnn_ctrl_cfg.svh */
`ifndef CNN_CTRL_CFG_SVH
`define CNN_CTRL_CFG_SVH

// ****************************************
// Network and memory sizing
// ****************************************

// Layers run per network pass, 1 to 13.
`define CNN_NUM_LAYER 13

// Depth of the main output feature-map RAM in words.
`define CNN_OFM_RAM_SIZE 2205619

// Address width for the main output feature-map RAM.
`define CNN_OFM_ADDR_W $clog2(`CNN_OFM_RAM_SIZE)

`endif

/* cnn_ctrl_pkg.sv */
package cnn_ctrl_pkg;

    `include "cnn_ctrl_cfg.svh"

    // ****************************************
    // Layer configuration field types
    // ****************************************

    // Zero is idle, above the layer count is finished.
    typedef logic [3:0]  layer_idx_t;

    typedef logic [8:0]  fmap_size_t;   // Edge length in pixels.
    typedef logic [10:0] channel_t;     // Channel or filter count.
    typedef logic [1:0]  kernel_t;      // Kernel edge, 1 or 3.
    typedef logic [1:0]  stride_t;      // Max-pool stride, 0 to 2.

    // Base address into the output feature-map RAM.
    typedef logic [`CNN_OFM_ADDR_W-1:0] ofm_addr_t;

endpackage

/* layer_sequencer.sv */
`timescale 1ns/100ps

`include "cnn_ctrl_cfg.svh"

module layer_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_cnn,
    input  logic                    done_layer,
    output cnn_ctrl_pkg::layer_idx_t layer_index,
    output logic                    start_layer,
    output logic                    done_cnn
);

    import cnn_ctrl_pkg::*;

    localparam layer_idx_t LAST_LAYER = layer_idx_t'(`CNN_NUM_LAYER);

    logic start_cnn_d;
    logic done_layer_d;
    logic start_rise;
    logic done_rise;
    logic step;

    // ****************************************
    // Edge detection
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_cnn_d  <= 1'b0;
            done_layer_d <= 1'b0;
        end else begin
            start_cnn_d  <= start_cnn;
            done_layer_d <= done_layer;
        end
    end

    assign start_rise = start_cnn & ~start_cnn_d;
    assign done_rise  = done_layer & ~done_layer_d;
    assign step       = start_rise | done_rise;

    // ****************************************
    // Layer counter and pulses
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_index <= '0;
            start_layer <= 1'b0;
            done_cnn    <= 1'b0;
        end else begin
            if (step && layer_index <= LAST_LAYER) begin
                layer_index <= layer_index + 1'b1;   // Stops one past the last layer.
            end
            start_layer <= step && (layer_index < LAST_LAYER);
            done_cnn    <= done_rise && (layer_index == LAST_LAYER);
        end
    end

endmodule

/* layer_config_rom.sv */
`timescale 1ns/100ps

module layer_config_rom (
    input  cnn_ctrl_pkg::layer_idx_t layer_index,
    output cnn_ctrl_pkg::fmap_size_t ifm_size,
    output cnn_ctrl_pkg::fmap_size_t ofm_size,
    output cnn_ctrl_pkg::channel_t   ifm_channel,
    output cnn_ctrl_pkg::channel_t   num_filter,
    output cnn_ctrl_pkg::kernel_t    kernel_size,
    output logic                     maxpool_mode,
    output cnn_ctrl_pkg::stride_t    maxpool_stride,
    output logic                     upsample_mode,
    output cnn_ctrl_pkg::ofm_addr_t  start_write_addr,
    output cnn_ctrl_pkg::ofm_addr_t  start_read_addr
);

    import cnn_ctrl_pkg::*;

    always_comb begin
        // Idle, finished and unused fields read as zero.
        ifm_size         = '0;
        ofm_size         = '0;
        ifm_channel      = '0;
        num_filter       = '0;
        kernel_size      = '0;
        maxpool_mode     = 1'b0;
        maxpool_stride   = '0;
        upsample_mode    = 1'b0;
        start_write_addr = '0;
        start_read_addr  = '0;

        case (layer_index)
            // ****************************************
            // Backbone, conv plus max-pool
            // ****************************************
            4'd1: begin
                ifm_size         = 9'd418;   // Padded 416 input.
                ofm_size         = 9'd208;
                ifm_channel      = 11'd3;
                kernel_size      = 2'd3;
                num_filter       = 11'd16;
                maxpool_mode     = 1'b1;
                maxpool_stride   = 2'd2;
            end
            4'd2: begin
                ifm_size         = 9'd208;
                ofm_size         = 9'd104;
                ifm_channel      = 11'd16;
                kernel_size      = 2'd3;
                num_filter       = 11'd32;
                maxpool_mode     = 1'b1;
                maxpool_stride   = 2'd2;
                start_write_addr = ofm_addr_t'(692224);
            end
            4'd3: begin
                ifm_size         = 9'd104;
                ofm_size         = 9'd52;
                ifm_channel      = 11'd32;
                kernel_size      = 2'd3;
                num_filter       = 11'd64;
                maxpool_mode     = 1'b1;
                maxpool_stride   = 2'd2;
                start_write_addr = ofm_addr_t'(1038336);
                start_read_addr  = ofm_addr_t'(692224);
            end
            4'd4: begin
                ifm_size         = 9'd52;
                ofm_size         = 9'd26;
                ifm_channel      = 11'd64;
                kernel_size      = 2'd3;
                num_filter       = 11'd128;
                maxpool_mode     = 1'b1;
                maxpool_stride   = 2'd2;
                start_write_addr = ofm_addr_t'(1211392);
                start_read_addr  = ofm_addr_t'(1038336);
            end
            4'd5: begin
                ifm_size         = 9'd26;
                ofm_size         = 9'd13;
                ifm_channel      = 11'd128;
                kernel_size      = 2'd3;
                num_filter       = 11'd256;
                maxpool_mode     = 1'b1;
                maxpool_stride   = 2'd2;
                start_write_addr = ofm_addr_t'(1297920);
                start_read_addr  = ofm_addr_t'(1211392);
            end
            4'd6: begin
                ifm_size         = 9'd13;
                ofm_size         = 9'd13;
                ifm_channel      = 11'd256;
                kernel_size      = 2'd3;
                num_filter       = 11'd512;
                maxpool_mode     = 1'b1;
                maxpool_stride   = 2'd1;     // Size kept by stride 1.
                start_write_addr = ofm_addr_t'(1341184);
                start_read_addr  = ofm_addr_t'(1297920);
            end
            // ****************************************
            // Detection head
            // ****************************************
            4'd7: begin
                ifm_size         = 9'd13;
                ofm_size         = 9'd13;
                ifm_channel      = 11'd512;
                kernel_size      = 2'd3;
                num_filter       = 11'd1024;
                start_write_addr = ofm_addr_t'(1427712);
                start_read_addr  = ofm_addr_t'(1341184);
            end
            4'd8: begin
                ifm_size         = 9'd13;
                ofm_size         = 9'd13;
                ifm_channel      = 11'd1024;
                kernel_size      = 2'd1;
                num_filter       = 11'd256;
                start_write_addr = ofm_addr_t'(1600768);
                start_read_addr  = ofm_addr_t'(1427712);
            end
            4'd9: begin
                ifm_size         = 9'd13;
                ofm_size         = 9'd13;
                ifm_channel      = 11'd256;
                kernel_size      = 2'd3;
                num_filter       = 11'd512;
                start_write_addr = ofm_addr_t'(1644032);
                start_read_addr  = ofm_addr_t'(1600768);
            end
            4'd10: begin
                ifm_size         = 9'd13;
                ofm_size         = 9'd13;
                ifm_channel      = 11'd512;
                kernel_size      = 2'd1;
                num_filter       = 11'd255;  // First detection output.
                start_write_addr = ofm_addr_t'(1730560);
                start_read_addr  = ofm_addr_t'(1644032);
            end
            4'd11: begin
                ifm_size         = 9'd13;
                ofm_size         = 9'd26;
                ifm_channel      = 11'd256;
                kernel_size      = 2'd1;
                num_filter       = 11'd128;
                upsample_mode    = 1'b1;
                start_write_addr = ofm_addr_t'(1773655);
                start_read_addr  = ofm_addr_t'(1600768);   // Branch from layer 8.
            end
            4'd12: begin
                ifm_size         = 9'd26;
                ofm_size         = 9'd26;
                ifm_channel      = 11'd384;  // Route concat.
                kernel_size      = 2'd3;
                num_filter       = 11'd256;
                start_write_addr = ofm_addr_t'(1860183);
            end
            4'd13: begin
                ifm_size         = 9'd26;
                ofm_size         = 9'd26;
                ifm_channel      = 11'd256;
                kernel_size      = 2'd1;
                num_filter       = 11'd255;  // Second detection output.
                start_write_addr = ofm_addr_t'(2033239);
                start_read_addr  = ofm_addr_t'(1860183);
            end
            default: begin
                ifm_size         = '0;
                ofm_size         = '0;
            end
        endcase
    end

endmodule

/* cnn_layer_ctrl.sv */
`timescale 1ns/100ps

module cnn_layer_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_cnn,
    input  logic                     done_layer,
    output logic                     start_layer,
    output logic                     done_cnn,
    output cnn_ctrl_pkg::layer_idx_t layer_index,
    output cnn_ctrl_pkg::fmap_size_t ifm_size,
    output cnn_ctrl_pkg::fmap_size_t ofm_size,
    output cnn_ctrl_pkg::channel_t   ifm_channel,
    output cnn_ctrl_pkg::channel_t   num_filter,
    output cnn_ctrl_pkg::kernel_t    kernel_size,
    output logic                     maxpool_mode,
    output cnn_ctrl_pkg::stride_t    maxpool_stride,
    output logic                     upsample_mode,
    output cnn_ctrl_pkg::ofm_addr_t  start_write_addr,
    output cnn_ctrl_pkg::ofm_addr_t  start_read_addr
);

    // ****************************************
    // Sequencer drives the table index
    // ****************************************

    layer_sequencer u_layer_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_cnn   (start_cnn),
        .done_layer  (done_layer),
        .layer_index (layer_index),
        .start_layer (start_layer),
        .done_cnn    (done_cnn)
    );

    layer_config_rom u_layer_config_rom (
        .layer_index      (layer_index),
        .ifm_size         (ifm_size),
        .ofm_size         (ofm_size),
        .ifm_channel      (ifm_channel),
        .num_filter       (num_filter),
        .kernel_size      (kernel_size),
        .maxpool_mode     (maxpool_mode),
        .maxpool_stride   (maxpool_stride),
        .upsample_mode    (upsample_mode),
        .start_write_addr (start_write_addr),
        .start_read_addr  (start_read_addr)
    );

endmodule

/* tb_cnn_layer_ctrl.sv */
`timescale 1ns/100ps

`include "cnn_ctrl_cfg.svh"

module tb_cnn_layer_ctrl;

    import cnn_ctrl_pkg::*;

    localparam int NUM_LAYER     = `CNN_NUM_LAYER;
    localparam int PULSE_TIMEOUT = 50;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       start_cnn;
    logic       done_layer;
    logic       start_layer;
    logic       done_cnn;
    layer_idx_t layer_index;
    fmap_size_t ifm_size;
    fmap_size_t ofm_size;
    channel_t   ifm_channel;
    channel_t   num_filter;
    kernel_t    kernel_size;
    logic       maxpool_mode;
    stride_t    maxpool_stride;
    logic       upsample_mode;
    ofm_addr_t  start_write_addr;
    ofm_addr_t  start_read_addr;

    int exp_idx;          // Model of the layer counter.
    int start_seen;
    int done_seen;
    int err_count;
    int test_errs;
    int pass_count;
    int fail_count;
    bit timed_out;

    // Reference rows. Index 0 and rows above the last layer stay zero.
    int ref_ifm [0:15];
    int ref_ofm [0:15];
    int ref_ich [0:15];
    int ref_nf  [0:15];
    int ref_k   [0:15];
    int ref_mp  [0:15];
    int ref_st  [0:15];
    int ref_up  [0:15];
    int ref_wa  [0:15];
    int ref_ra  [0:15];

    cnn_layer_ctrl DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_cnn        (start_cnn),
        .done_layer       (done_layer),
        .start_layer      (start_layer),
        .done_cnn         (done_cnn),
        .layer_index      (layer_index),
        .ifm_size         (ifm_size),
        .ofm_size         (ofm_size),
        .ifm_channel      (ifm_channel),
        .num_filter       (num_filter),
        .kernel_size      (kernel_size),
        .maxpool_mode     (maxpool_mode),
        .maxpool_stride   (maxpool_stride),
        .upsample_mode    (upsample_mode),
        .start_write_addr (start_write_addr),
        .start_read_addr  (start_read_addr)
    );

    always #20 clk = ~clk;

    // Pulse counts, sampled mid-cycle.
    always @(negedge clk) begin
        if (start_layer === 1'b1) start_seen++;
        if (done_cnn === 1'b1) done_seen++;
    end

    // ****************************************
    // Helpers
    // ****************************************

    task automatic tick;
        @(posedge clk);
        #2;
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            err_count++;
        end
    endtask

    task automatic set_row(input int idx, input int ifm, input int ofm, input int ich,
                           input int nf, input int k, input int mp, input int st,
                           input int up, input int wa, input int ra);
        ref_ifm[idx] = ifm;
        ref_ofm[idx] = ofm;
        ref_ich[idx] = ich;
        ref_nf[idx]  = nf;
        ref_k[idx]   = k;
        ref_mp[idx]  = mp;
        ref_st[idx]  = st;
        ref_up[idx]  = up;
        ref_wa[idx]  = wa;
        ref_ra[idx]  = ra;
    endtask

    task automatic load_reference;
        // Each row gives ifm, ofm, in channels, filters, kernel, pool, stride, upsample,
        // write and read.
        set_row(1, 418, 208, 3, 16, 3, 1, 2, 0, 0, 0);
        set_row(2, 208, 104, 16, 32, 3, 1, 2, 0, 692224, 0);
        set_row(3, 104, 52, 32, 64, 3, 1, 2, 0, 1038336, 692224);
        set_row(4, 52, 26, 64, 128, 3, 1, 2, 0, 1211392, 1038336);
        set_row(5, 26, 13, 128, 256, 3, 1, 2, 0, 1297920, 1211392);
        set_row(6, 13, 13, 256, 512, 3, 1, 1, 0, 1341184, 1297920);
        set_row(7, 13, 13, 512, 1024, 3, 0, 0, 0, 1427712, 1341184);
        set_row(8, 13, 13, 1024, 256, 1, 0, 0, 0, 1600768, 1427712);
        set_row(9, 13, 13, 256, 512, 3, 0, 0, 0, 1644032, 1600768);
        set_row(10, 13, 13, 512, 255, 1, 0, 0, 0, 1730560, 1644032);
        set_row(11, 13, 26, 256, 128, 1, 0, 0, 1, 1773655, 1600768);
        set_row(12, 26, 26, 384, 256, 3, 0, 0, 0, 1860183, 0);
        set_row(13, 26, 26, 256, 255, 1, 0, 0, 0, 2033239, 1860183);
    endtask

    task automatic check_fields(input int idx);
        check("ifm_size", 32'(ifm_size), ref_ifm[idx]);
        check("ofm_size", 32'(ofm_size), ref_ofm[idx]);
        check("ifm_channel", 32'(ifm_channel), ref_ich[idx]);
        check("num_filter", 32'(num_filter), ref_nf[idx]);
        check("kernel_size", 32'(kernel_size), ref_k[idx]);
        check("maxpool_mode", 32'(maxpool_mode), ref_mp[idx]);
        check("maxpool_stride", 32'(maxpool_stride), ref_st[idx]);
        check("upsample_mode", 32'(upsample_mode), ref_up[idx]);
        check("start_write_addr", 32'(start_write_addr), ref_wa[idx]);
        check("start_read_addr", 32'(start_read_addr), ref_ra[idx]);
    endtask

    task automatic apply_reset;
        rst_n      = 1'b0;
        start_cnn  = 1'b0;
        done_layer = 1'b0;
        repeat (4) tick;
        rst_n   = 1'b1;
        exp_idx = 0;
        tick;
    endtask

    // ****************************************
    // Event driver with the counter model
    // ****************************************

    task automatic apply_event(input bit use_done, input int hold);
        bit exp_start;
        bit exp_done;
        int start_before;
        int done_before;
        int cycles;
        if (timed_out) return;
        exp_start = (exp_idx < NUM_LAYER);
        exp_done  = use_done && (exp_idx == NUM_LAYER);
        if (exp_idx <= NUM_LAYER) exp_idx++;   // Saturates one past the last layer.
        start_before = start_seen;
        done_before  = done_seen;
        cycles       = 0;
        if (use_done) done_layer = 1'b1;
        else start_cnn = 1'b1;
        if (exp_start || exp_done) begin
            tick;
            cycles = 1;
            while (start_layer !== 1'b1 && done_cnn !== 1'b1 && cycles < PULSE_TIMEOUT) begin
                tick;
                cycles++;
            end
            if (start_layer !== 1'b1 && done_cnn !== 1'b1) begin
                $display("Timeout: no start_layer or done_cnn pulse within %0d cycles",
                         PULSE_TIMEOUT);
                timed_out = 1'b1;
            end
            check("pulse latency", cycles, 1);
            check("layer_index at pulse", 32'(layer_index), exp_idx);
            check_fields(exp_idx);
        end
        while (cycles < hold) begin
            tick;
            cycles++;
        end
        start_cnn  = 1'b0;
        done_layer = 1'b0;
        tick;
        tick;
        check("start_layer pulses", start_seen - start_before, 32'(exp_start));
        check("done_cnn pulses", done_seen - done_before, 32'(exp_done));
        check("layer_index", 32'(layer_index), exp_idx);
        check_fields(exp_idx);
    endtask

    task automatic end_test(input string name);
        if (err_count == test_errs && !timed_out) begin
            pass_count++;
            $display("Test %s: ok", name);
        end else begin
            fail_count++;
            $display("Test %s: failed", name);
        end
    endtask

    // ****************************************
    // Test sequence
    // ****************************************

    initial begin
        int layer;
        int extra;
        int walk_start;
        int sat_start;
        int sat_done;
        rst_n      = 1'b0;
        start_cnn  = 1'b0;
        done_layer = 1'b0;
        err_count  = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        void'($urandom(31890));
        load_reference;
        apply_reset;

        test_errs = err_count;
        check("start_layer", 32'(start_layer), 0);
        check("done_cnn", 32'(done_cnn), 0);
        check("layer_index", 32'(layer_index), 0);
        check_fields(0);
        end_test("reset");

        test_errs = err_count;
        repeat ($urandom_range(20, 1)) tick;
        apply_event(1'b0, 1);
        end_test("first layer");

        test_errs  = err_count;
        walk_start = start_seen;
        for (layer = 2; layer <= NUM_LAYER; layer++) begin
            repeat ($urandom_range(20, 1)) tick;   // Engine busy.
            apply_event(1'b1, 1);
        end
        check("walk start_layer pulses", start_seen - walk_start, NUM_LAYER - 1);
        end_test("layer walk");

        test_errs = err_count;
        repeat ($urandom_range(20, 1)) tick;
        apply_event(1'b1, 1);
        end_test("network done");

        test_errs = err_count;
        sat_start = start_seen;
        sat_done  = done_seen;
        for (extra = $urandom_range(5, 2); extra > 0; extra--) begin
            repeat ($urandom_range(20, 1)) tick;
            apply_event($urandom_range(1, 0) == 1, $urandom_range(3, 1));
        end
        check("extra start_layer pulses", start_seen - sat_start, 0);
        check("extra done_cnn pulses", done_seen - sat_done, 0);
        apply_reset;
        check("layer_index after reset", 32'(layer_index), 0);
        apply_event(1'b0, $urandom_range(8, 3));   // Held start advances once.
        apply_event(1'b1, $urandom_range(8, 3));
        end_test("edge sensing and saturation");

        $display("Tests passed: %0d, failed: %0d, errors: %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* cnn_layer_ctrl.f */
+incdir+.
cnn_ctrl_pkg.sv
layer_sequencer.sv
layer_config_rom.sv
cnn_layer_ctrl.sv
tb_cnn_layer_ctrl.sv

/* Makefile */
# Verilator build for the CNN layer controller.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_cnn_layer_ctrl
FILELIST  ?= cnn_layer_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --timing

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || \
		{ echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
